//--- synctimer_pkg.sv
package synctimer_pkg;

    // ------------------------------
    // timer format
    // ------------------------------

    localparam int TIMER_WIDTH = 64;   // ns

    // per-clock step is NUMERATOR/DENOMINATOR ns
    localparam int NUMERATOR   = 10;
    localparam int DENOMINATOR = 3;

    localparam int STEP_INT  = NUMERATOR / DENOMINATOR;
    localparam int STEP_FRAC = NUMERATOR % DENOMINATOR;

    // remainder accumulator, must hold DENOMINATOR-1
    localparam int FRAC_WIDTH = 2;

    // ------------------------------
    // correction and measurement
    // ------------------------------

    // max phase nudge per adjust frame
    localparam int PHASE_LIMIT = 10;

    // turnaround result, sent as 4 bytes
    localparam int ELAPSED_WIDTH = 32;

endpackage

//--- frame_pkg.sv
package frame_pkg;

    // byte position counter width on both rings
    localparam int POS_WIDTH = 16;

    // ------------------------------
    // command frame
    // ------------------------------

    typedef enum logic [7:0] {
        cmd_nop    = 8'h00,
        cmd_adjust = 8'h01,
        cmd_set    = 8'h03
    } cmd_op_e;

    localparam int POS_OP       = 0;
    localparam int POS_TIME     = 1;   // little endian
    localparam int TIME_BYTES   = 8;
    localparam int POS_OFFSET   = 9;   // little endian
    localparam int OFFSET_BYTES = 2;

    // ------------------------------
    // response frame
    // ------------------------------

    localparam int RES_SLOT_BASE  = 9;   // first node slot
    localparam int RES_SLOT_BYTES = 4;

endpackage

//--- cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
    input  logic                                  clk,
    input  logic                                  up_reset,
    input  logic                                  cmd_rx_start,
    input  logic                                  cmd_rx_end,
    input  logic                                  cmd_rx_error,
    input  logic [7:0]                            cmd_rx_node,
    input  logic [frame_pkg::POS_WIDTH-1:0]       s_cmd_pos,
    input  logic [7:0]                            s_cmd_data,
    input  logic                                  s_cmd_valid,
    output logic                                  correct_valid,
    output logic                                  correct_override,
    output logic [synctimer_pkg::TIMER_WIDTH-1:0] correct_time,
    output logic                                  frame_done,
    output logic [7:0]                            node_id
);
    import synctimer_pkg::*;
    import frame_pkg::*;

    cmd_op_e                   cmd_op;
    logic [TIMER_WIDTH-1:0]    cmd_time;
    logic [8*OFFSET_BYTES-1:0] cmd_offset;
    logic                      aborted;
    logic                      frame_ok;

    assign frame_ok = cmd_rx_end && !aborted && !cmd_rx_error;

    // ------------------------------
    // field capture
    // ------------------------------

    always_ff @(posedge clk) begin
        if (s_cmd_valid) begin
            if (s_cmd_pos == POS_WIDTH'(POS_OP)) begin
                cmd_op <= cmd_op_e'(s_cmd_data);
            end
            for (int i = 0; i < TIME_BYTES; i++) begin
                if (s_cmd_pos == POS_WIDTH'(POS_TIME + i)) begin
                    cmd_time[8*i +: 8] <= s_cmd_data;
                end
            end
            for (int i = 0; i < OFFSET_BYTES; i++) begin
                if (s_cmd_pos == POS_WIDTH'(POS_OFFSET + i)) begin
                    cmd_offset[8*i +: 8] <= s_cmd_data;
                end
            end
        end
    end

    // error anywhere in the frame kills it
    always_ff @(posedge clk) begin
        if (up_reset) begin
            aborted <= 1'b0;
        end else if (cmd_rx_start) begin
            aborted <= cmd_rx_error;
        end else if (cmd_rx_error) begin
            aborted <= 1'b1;
        end
    end

    // ------------------------------
    // decode at frame end
    // ------------------------------

    always_ff @(posedge clk) begin
        if (up_reset) begin
            frame_done    <= 1'b0;
            correct_valid <= 1'b0;
            node_id       <= '0;
        end else begin
            frame_done    <= frame_ok;
            correct_valid <= frame_ok && (cmd_op != cmd_nop);
            if (cmd_rx_end) begin
                node_id <= cmd_rx_node;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_ok) begin
            correct_time <= cmd_time + TIMER_WIDTH'(cmd_offset);   // master time + offset
            case (cmd_op)
                cmd_nop:    correct_override <= 1'b0;
                cmd_adjust: correct_override <= 1'b0;
                cmd_set:    correct_override <= 1'b1;
                default:    correct_override <= 1'b1;   // unknown op acts as set
            endcase
        end
    end

endmodule

//--- timer_core.sv
`timescale 1ns/1ps

module timer_core (
    input  logic                                  clk,
    input  logic                                  up_reset,
    input  logic                                  correct_valid,
    input  logic                                  correct_override,
    input  logic [synctimer_pkg::TIMER_WIDTH-1:0] correct_time,
    output logic [synctimer_pkg::TIMER_WIDTH-1:0] current_time
);
    import synctimer_pkg::*;

    logic [FRAC_WIDTH-1:0]         frac_acc;
    logic [FRAC_WIDTH:0]           frac_sum;
    logic                          frac_carry;
    logic [FRAC_WIDTH-1:0]         frac_next;
    logic [TIMER_WIDTH-1:0]        step;
    logic signed [TIMER_WIDTH-1:0] phase_err;
    logic signed [TIMER_WIDTH-1:0] phase_adj;

    // ------------------------------
    // rational step
    // ------------------------------

    // remainder wraps at DENOMINATOR and carries 1 ns into the step
    always_comb begin
        frac_sum   = (FRAC_WIDTH+1)'(frac_acc) + (FRAC_WIDTH+1)'(STEP_FRAC);
        frac_carry = (frac_sum >= (FRAC_WIDTH+1)'(DENOMINATOR));
        if (frac_carry) begin
            frac_next = FRAC_WIDTH'(frac_sum - (FRAC_WIDTH+1)'(DENOMINATOR));
        end else begin
            frac_next = FRAC_WIDTH'(frac_sum);
        end
        step = TIMER_WIDTH'(STEP_INT) + TIMER_WIDTH'(frac_carry);
    end

    // ------------------------------
    // phase error, saturated
    // ------------------------------

    always_comb begin
        phase_err = $signed(correct_time - current_time);
        if (phase_err > $signed(TIMER_WIDTH'(PHASE_LIMIT))) begin
            phase_adj = $signed(TIMER_WIDTH'(PHASE_LIMIT));
        end else if (phase_err < -$signed(TIMER_WIDTH'(PHASE_LIMIT))) begin
            phase_adj = -$signed(TIMER_WIDTH'(PHASE_LIMIT));
        end else begin
            phase_adj = phase_err;
        end
    end

    // ------------------------------
    // timer register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (up_reset) begin
            current_time <= '0;
            frac_acc     <= '0;
        end else if (correct_valid && correct_override) begin
            current_time <= correct_time;   // hard set
            frac_acc     <= '0;
        end else if (correct_valid) begin
            // nudge on top of normal step
            current_time <= current_time + step + $unsigned(phase_adj);
            frac_acc     <= frac_next;
        end else begin
            current_time <= current_time + step;
            frac_acc     <= frac_next;
        end
    end

endmodule

//--- turnaround_meter.sv
`timescale 1ns/1ps

module turnaround_meter (
    input  logic                                    clk,
    input  logic                                    up_reset,
    input  logic                                    frame_done,
    input  logic                                    correct_override,
    input  logic [synctimer_pkg::TIMER_WIDTH-1:0]   correct_time,
    input  logic [synctimer_pkg::TIMER_WIDTH-1:0]   current_time,
    input  logic                                    res_rx_start,
    output logic [synctimer_pkg::ELAPSED_WIDTH-1:0] elapsed_time
);
    import synctimer_pkg::*;

    logic [ELAPSED_WIDTH-1:0] start_time;
    logic [ELAPSED_WIDTH-1:0] now_low;

    assign now_low = current_time[ELAPSED_WIDTH-1:0];

    // after a set the timer jumps, so start from the target
    always_ff @(posedge clk) begin
        if (up_reset) begin
            start_time <= '0;
        end else if (frame_done) begin
            if (correct_override) begin
                start_time <= correct_time[ELAPSED_WIDTH-1:0];
            end else begin
                start_time <= now_low;
            end
        end
    end

    // command end to response start
    always_ff @(posedge clk) begin
        if (up_reset) begin
            elapsed_time <= '0;
        end else if (res_rx_start) begin
            elapsed_time <= now_low - start_time;   // wraps mod 2^32
        end
    end

endmodule

//--- response_inserter.sv
`timescale 1ns/1ps

module response_inserter (
    input  logic                                    clk,
    input  logic                                    up_reset,
    input  logic [7:0]                              node_id,
    input  logic [synctimer_pkg::ELAPSED_WIDTH-1:0] elapsed_time,
    input  logic [frame_pkg::POS_WIDTH-1:0]         s_res_pos,
    input  logic                                    s_res_valid,
    output logic [7:0]                              m_res_data,
    output logic                                    m_res_valid
);
    import synctimer_pkg::*;
    import frame_pkg::*;

    logic [POS_WIDTH-1:0] slot_base;
    logic                 slot_hit;
    logic [7:0]           slot_byte;

    // node n owns bytes base + 4n .. base + 4n + 3
    assign slot_base = POS_WIDTH'(RES_SLOT_BASE)
                     + POS_WIDTH'(node_id) * POS_WIDTH'(RES_SLOT_BYTES);

    always_comb begin
        slot_hit  = 1'b0;
        slot_byte = '0;
        for (int k = 0; k < RES_SLOT_BYTES; k++) begin
            if (s_res_pos == slot_base + POS_WIDTH'(k)) begin
                slot_hit  = 1'b1;
                slot_byte = elapsed_time[8*k +: 8];   // little endian
            end
        end
    end

    // ------------------------------
    // output register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (up_reset) begin
            m_res_valid <= 1'b0;
        end else begin
            m_res_valid <= s_res_valid && slot_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (s_res_valid && slot_hit) begin
            m_res_data <= slot_byte;
        end
    end

endmodule

//--- synctimer_slave.sv
`timescale 1ns/1ps

module synctimer_slave (
    input  logic                                  clk,
    input  logic                                  up_reset,

    // command ring
    input  logic                                  cmd_rx_start,
    input  logic                                  cmd_rx_end,
    input  logic                                  cmd_rx_error,
    input  logic [7:0]                            cmd_rx_node,
    input  logic [frame_pkg::POS_WIDTH-1:0]       s_cmd_pos,
    input  logic [7:0]                            s_cmd_data,
    input  logic                                  s_cmd_valid,

    // response ring
    input  logic                                  res_rx_start,
    input  logic [frame_pkg::POS_WIDTH-1:0]       s_res_pos,
    input  logic                                  s_res_valid,
    output logic [7:0]                            m_res_data,
    output logic                                  m_res_valid,

    output logic [synctimer_pkg::TIMER_WIDTH-1:0] current_time
);
    import synctimer_pkg::*;

    logic                     correct_valid;
    logic                     correct_override;
    logic [TIMER_WIDTH-1:0]   correct_time;
    logic                     frame_done;
    logic [7:0]               node_id;
    logic [ELAPSED_WIDTH-1:0] elapsed_time;

    // ------------------------------
    // command side
    // ------------------------------

    cmd_parser u_cmd_parser (
        .clk              (clk),
        .up_reset         (up_reset),
        .cmd_rx_start     (cmd_rx_start),
        .cmd_rx_end       (cmd_rx_end),
        .cmd_rx_error     (cmd_rx_error),
        .cmd_rx_node      (cmd_rx_node),
        .s_cmd_pos        (s_cmd_pos),
        .s_cmd_data       (s_cmd_data),
        .s_cmd_valid      (s_cmd_valid),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .correct_time     (correct_time),
        .frame_done       (frame_done),
        .node_id          (node_id)
    );

    // ------------------------------
    // timer and turnaround
    // ------------------------------

    timer_core u_timer_core (
        .clk              (clk),
        .up_reset         (up_reset),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .correct_time     (correct_time),
        .current_time     (current_time)
    );

    turnaround_meter u_turnaround_meter (
        .clk              (clk),
        .up_reset         (up_reset),
        .frame_done       (frame_done),
        .correct_override (correct_override),
        .correct_time     (correct_time),
        .current_time     (current_time),
        .res_rx_start     (res_rx_start),
        .elapsed_time     (elapsed_time)
    );

    // response side
    response_inserter u_response_inserter (
        .clk          (clk),
        .up_reset     (up_reset),
        .node_id      (node_id),
        .elapsed_time (elapsed_time),
        .s_res_pos    (s_res_pos),
        .s_res_valid  (s_res_valid),
        .m_res_data   (m_res_data),
        .m_res_valid  (m_res_valid)
    );

endmodule

//--- synctimer_chk.sv
`timescale 1ns/1ps

module synctimer_chk (
    input logic                                  clk,
    input logic                                  up_reset,
    input logic                                  correct_valid,
    input logic [synctimer_pkg::TIMER_WIDTH-1:0] current_time,
    input logic                                  s_res_valid,
    input logic                                  m_res_valid
);
    import synctimer_pkg::*;

    // floor and ceiling of the 10/3 step
    localparam logic [TIMER_WIDTH-1:0] STEP_LO = TIMER_WIDTH'(NUMERATOR / DENOMINATOR);
    localparam logic [TIMER_WIDTH-1:0] STEP_HI = STEP_LO + 64'd1;

    int fail_count = 0;

    // ------------------------------
    // response output
    // ------------------------------

    quiet_after_reset: assert property (
        @(posedge clk) up_reset |=> !m_res_valid
    ) else begin
        fail_count++;
        $error("m_res_valid high during or right after reset");
    end

    no_output_without_input: assert property (
        @(posedge clk) disable iff (up_reset)
        $rose(m_res_valid) |-> $past(s_res_valid)
    ) else begin
        fail_count++;
        $error("m_res_valid rose with no response byte the cycle before");
    end

    // timer free run, corrections excluded
    free_run_step: assert property (
        @(posedge clk) disable iff (up_reset)
        (!$past(up_reset) && !$past(correct_valid))
            |-> ((current_time - $past(current_time) == STEP_LO)
              || (current_time - $past(current_time) == STEP_HI))
    ) else begin
        fail_count++;
        $error("current_time step outside 3..4 without a correction");
    end

endmodule

bind synctimer_slave synctimer_chk u_chk (
    .clk           (clk),
    .up_reset      (up_reset),
    .correct_valid (correct_valid),
    .current_time  (current_time),
    .s_res_valid   (s_res_valid),
    .m_res_valid   (m_res_valid)
);

//--- tb_synctimer_slave.sv
`timescale 1ns/1ps

module tb_synctimer_slave;
    import synctimer_pkg::*;
    import frame_pkg::*;

    localparam int NUM_FRAMES     = 11;
    localparam int FRAME_CYCLES   = 48;   // response frame plus idle
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 300;
    localparam int RES_LEN        = RES_SLOT_BASE + 8 * RES_SLOT_BYTES;
    localparam int CMD_TO_DONE    = 13;   // clocks from first byte to the frame_done cycle

    logic        clk = 1'b0;
    logic        up_reset;
    logic        cmd_rx_start;
    logic        cmd_rx_end;
    logic        cmd_rx_error;
    logic [7:0]  cmd_rx_node;
    logic [15:0] s_cmd_pos;
    logic [7:0]  s_cmd_data;
    logic        s_cmd_valid;
    logic        res_rx_start;
    logic [15:0] s_res_pos;
    logic        s_res_valid;
    logic [7:0]  m_res_data;
    logic        m_res_valid;
    logic [63:0] current_time;

    // reference model
    logic [63:0] exp_base = '0;
    logic [63:0] exp_n = '0;   // clocks since last set
    logic [63:0] exp_time = '0;
    logic        run = 1'b0;
    int          pend_cnt = 0;
    logic [7:0]  pend_op;
    logic [63:0] pend_target;
    logic [63:0] pend_adj;
    logic [31:0] exp_start = '0;
    logic [31:0] exp_elapsed = '0;
    logic [7:0]  exp_node = '0;
    logic        exp_vld = 1'b0;
    logic [7:0]  exp_data;
    int          out_count = 0;
    int          errors = 0;
    integer      seed;

    synctimer_slave DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [63:0] time_ahead(input int k);
        return exp_base + ((exp_n + 64'(k)) * 64'(NUMERATOR)) / 64'(DENOMINATOR);
    endfunction

    function automatic bit set_like(input logic [7:0] op);
        return op != cmd_nop && op != cmd_adjust;   // unknown codes load the timer
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("mismatch at %0t: %s got %0h, expected %0h", $time, name, got, want);
    endtask

    // ------------------------------
    // model steps on falling edge
    // ------------------------------

    always @(negedge clk) begin
        logic signed [63:0] err;
        logic [15:0]        slot;
        if (run) begin
            exp_n = exp_n + 64'd1;
        end
        run = !up_reset;
        exp_time = exp_base + (exp_n * 64'(NUMERATOR)) / 64'(DENOMINATOR);
        if (pend_cnt == 2) begin
            // frame_done cycle
            err = $signed(pend_target - exp_time);
            if (err > 64'(PHASE_LIMIT)) begin
                err = 64'(PHASE_LIMIT);
            end else if (err < -64'(PHASE_LIMIT)) begin
                err = -64'(PHASE_LIMIT);
            end
            pend_adj  = err;
            exp_start = set_like(pend_op) ? pend_target[31:0] : exp_time[31:0];
        end else if (pend_cnt == 1 && pend_op == cmd_adjust) begin
            exp_base = exp_base + pend_adj;   // on top of the normal step
            exp_time = exp_time + pend_adj;
        end else if (pend_cnt == 1 && set_like(pend_op)) begin
            exp_base = pend_target;
            exp_n    = '0;
            exp_time = pend_target;
        end
        if (pend_cnt != 0) begin
            pend_cnt = pend_cnt - 1;
        end
        assert (current_time === exp_time) else begin
            report_mismatch("current_time", current_time, exp_time);
        end
        if (res_rx_start) begin
            exp_elapsed = exp_time[31:0] - exp_start;
        end
        assert (m_res_valid === exp_vld) else begin
            report_mismatch("m_res_valid", 64'(m_res_valid), 64'(exp_vld));
        end
        if (exp_vld) begin
            assert (m_res_data === exp_data) else begin
                report_mismatch("m_res_data", 64'(m_res_data), 64'(exp_data));
            end
        end
        if (m_res_valid) begin
            out_count++;
        end
        // byte k of the slot comes out next cycle
        slot     = 16'(RES_SLOT_BASE) + 16'(exp_node) * 16'(RES_SLOT_BYTES);
        exp_vld  = !up_reset && s_res_valid
                && s_res_pos >= slot && s_res_pos < slot + 16'(RES_SLOT_BYTES);
        exp_data = 8'(exp_elapsed >> (8 * (s_res_pos - slot)));
    end

    // ------------------------------
    // frame drivers
    // ------------------------------

    task automatic send_cmd(input logic [7:0] op, input logic [63:0] target, input bit abort);
        logic [15:0] offset;
        logic [7:0]  node;
        logic [87:0] frame;
        offset = 16'($random(seed));
        node   = 8'($random(seed) & 7);
        frame  = {offset, target - 64'(offset), op};   // little endian op, time and offset
        for (int i = 0; i < POS_OFFSET + 2; i++) begin
            cmd_rx_start <= (i == 0);
            cmd_rx_error <= abort && (i == 5);
            s_cmd_valid  <= 1'b1;
            s_cmd_pos    <= 16'(i);
            s_cmd_data   <= frame[8*i +: 8];
            @(posedge clk);
        end
        s_cmd_valid <= 1'b0;
        cmd_rx_end  <= 1'b1;
        cmd_rx_node <= node;
        exp_node = node;
        if (!abort) begin
            pend_cnt    = 3;
            pend_op     = op;
            pend_target = target;
        end
        @(posedge clk);
        cmd_rx_end <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_res();
        out_count = 0;
        for (int i = 0; i < RES_LEN; i++) begin
            res_rx_start <= (i == 0);
            s_res_valid  <= 1'b1;
            s_res_pos    <= 16'(i);
            @(posedge clk);
        end
        s_res_valid <= 1'b0;
        repeat (3) @(posedge clk);
        assert (out_count == RES_SLOT_BYTES) else begin
            report_mismatch("m_res_valid count", 64'(out_count), 64'(RES_SLOT_BYTES));
        end
    endtask

    initial begin
        seed         = 32'h40effb99;
        up_reset     = 1'b1;
        cmd_rx_start = 1'b0;
        cmd_rx_end   = 1'b0;
        cmd_rx_error = 1'b0;
        cmd_rx_node  = '0;
        s_cmd_pos    = '0;
        s_cmd_data   = '0;
        s_cmd_valid  = 1'b0;
        res_rx_start = 1'b0;
        s_res_pos    = 16'(RES_SLOT_BASE);
        s_res_valid  = 1'b1;   // node 0 slot byte held during reset
        repeat (16) @(posedge clk);
        up_reset    <= 1'b0;
        s_res_valid <= 1'b0;
        repeat (24) @(posedge clk);   // free run from zero

        send_cmd(cmd_set, {$random(seed), $random(seed)}, 1'b0);
        send_res();
        send_cmd(8'h7e, {$random(seed), $random(seed)}, 1'b0);
        send_cmd(cmd_adjust, time_ahead(CMD_TO_DONE) + 64'd5, 1'b0);
        send_cmd(cmd_adjust, time_ahead(CMD_TO_DONE) + 64'd200, 1'b0);
        send_res();
        send_cmd(cmd_adjust, time_ahead(CMD_TO_DONE) - 64'd200, 1'b0);
        send_cmd(cmd_nop, time_ahead(CMD_TO_DONE), 1'b0);
        send_res();
        send_cmd(cmd_set, {$random(seed), $random(seed)}, 1'b1);   // killed by cmd_rx_error
        send_res();

        $display("errors: %0d model mismatches, %0d assertion failures",
                 errors, DUT.u_chk.fail_count);
        if (errors == 0 && DUT.u_chk.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * 10);
        $display("timeout: stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- src.f
synctimer_pkg.sv
frame_pkg.sv
cmd_parser.sv
timer_core.sv
turnaround_meter.sv
response_inserter.sv
synctimer_slave.sv
synctimer_chk.sv
tb_synctimer_slave.sv

//--- Makefile
SIM = obj_dir/Vtb_synctimer_slave

all: run

$(SIM): src.f $(wildcard *.sv)
	verilator --binary --assert -j 0 --top-module tb_synctimer_slave -f src.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only -Wall --top-module synctimer_slave synctimer_pkg.sv frame_pkg.sv \
		cmd_parser.sv timer_core.sv turnaround_meter.sv response_inserter.sv synctimer_slave.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
